// ==== rtl/core_pkg.sv ====
// core_pkg
// shared widths, CSR addresses, ALU and exception encodings, and the
// stage payload structs of the RV64 execution slice
`default_nettype none

package core_pkg;

  localparam int xlen       = 64;
  localparam int reg_addr_w = 5;
  localparam int csr_addr_w = 12;

  localparam logic [csr_addr_w-1:0] csr_mcycle   = 12'hb00;
  localparam logic [csr_addr_w-1:0] csr_minstret = 12'hb02;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_or,
    alu_and,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_andn,
    alu_wri
  } alu_op_e;

  typedef enum logic [1:0] {
    excp_none,
    excp_illegal,
    excp_ecall,
    excp_ebreak
  } excp_e;

  typedef struct packed {
    logic [31:0]     inst;
    logic [xlen-1:0] pc;
  } if_id_t;

  // csr_addr is zero for anything that is not a CSR instruction
  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       op1;
    logic [xlen-1:0]       op2;
    alu_op_e               alu_op;
    logic                  is_word;
    logic [reg_addr_w-1:0] rd;
    logic                  rd_wen;
    logic                  csr_wen;
    logic [csr_addr_w-1:0] csr_addr;
    logic [xlen-1:0]       csr_rdata;
    excp_e                 excp;
  } id_ex_t;

endpackage

`default_nettype wire

// ==== rtl/stage_reg.sv ====
// stage_reg
// one pipeline stage: valid flag plus payload, with valid/allowin flow control
`default_nettype none

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  output logic     allowin,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     ready_go,
  input  logic     out_allowin
);

  logic valid;

  // empty, or the current contents leave this cycle
  assign allowin   = !valid || (ready_go && out_allowin);
  assign out_valid = valid && ready_go;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else if (allowin) begin
      valid <= in_valid;
    end
  end

  // payload only
  always_ff @(posedge clk) begin
    if (in_valid && allowin) begin
      out_data <= in_data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/regfile.sv ====
// regfile
// 31 writable 64-bit integer registers, x0 hardwired to zero,
// two combinational read ports and one write port
`default_nettype none

module regfile
  import core_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [reg_addr_w-1:0] rs1_addr,
  input  logic [reg_addr_w-1:0] rs2_addr,
  output logic [xlen-1:0]       rs1_data,
  output logic [xlen-1:0]       rs2_data,
  input  logic                  wen,
  input  logic [reg_addr_w-1:0] waddr,
  input  logic [xlen-1:0]       wdata
);

  localparam int nregs = 1 << reg_addr_w;

  logic [xlen-1:0] regs [1:nregs-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < nregs; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // no bypass, a write shows up on the next cycle
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== rtl/id_stage.sv ====
// id_stage
// RV64I arithmetic, lui/auipc, CSR and ecall/ebreak decode with operand
// selection and the read-after-write interlock against EX
`default_nettype none

module id_stage
  import core_pkg::*;
(
  input  logic [31:0]           inst,
  input  logic [xlen-1:0]       pc,
  input  logic [xlen-1:0]       rs1_data,
  input  logic [xlen-1:0]       rs2_data,
  output logic [reg_addr_w-1:0] rs1_addr,
  output logic [reg_addr_w-1:0] rs2_addr,
  output logic [csr_addr_w-1:0] csr_raddr,
  input  logic [xlen-1:0]       csr_rdata,
  input  logic                  ex_valid,
  input  logic [reg_addr_w-1:0] ex_rd,
  input  logic                  ex_rd_wen,
  output logic                  ready_go,
  output id_ex_t                id_ex
);

  logic [6:0]  opcode;
  logic [2:0]  func3;
  logic [5:0]  func6;
  logic [6:0]  func7;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [11:0] imm_i;
  logic [19:0] imm_u;

  assign opcode = inst[6:0];
  assign func3  = inst[14:12];
  assign func6  = inst[31:26];
  assign func7  = inst[31:25];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign imm_i  = inst[31:20];
  assign imm_u  = inst[31:12];

  logic op_imm, op_imm_w, op_reg, op_reg_w, op_lui, op_auipc, op_sys;

  assign op_imm   = (opcode == 7'h13);
  assign op_imm_w = (opcode == 7'h1b);
  assign op_reg   = (opcode == 7'h33);
  assign op_reg_w = (opcode == 7'h3b);
  assign op_lui   = (opcode == 7'h37);
  assign op_auipc = (opcode == 7'h17);
  assign op_sys   = (opcode == 7'h73);

  logic imm_ok, imm_w_ok, reg_ok, reg_w_ok;
  logic is_ecall, is_ebreak, is_csr, csr_ok, legal;

  // shift forms constrain the upper function bits
  assign imm_ok   = op_imm && ((func3 == 3'd1) ? (func6 == 6'h00) :
                               (func3 == 3'd5) ? (func6 == 6'h00 || func6 == 6'h10) : 1'b1);
  assign imm_w_ok = op_imm_w && (func3 == 3'd0 || (func3 == 3'd1 && func7 == 7'h00) ||
                                 (func3 == 3'd5 && (func7 == 7'h00 || func7 == 7'h20)));
  assign reg_ok   = op_reg && (func7 == 7'h00 ||
                               (func7 == 7'h20 && (func3 == 3'd0 || func3 == 3'd5)));
  assign reg_w_ok = op_reg_w && (func3 == 3'd0 || func3 == 3'd1 || func3 == 3'd5) &&
                    (func7 == 7'h00 || (func7 == 7'h20 && func3 != 3'd1));

  assign is_ecall  = op_sys && (func3 == 3'd0) && (imm_i == 12'h000);
  assign is_ebreak = op_sys && (func3 == 3'd0) && (imm_i == 12'h001);
  assign is_csr    = op_sys && (func3[1:0] != 2'd0);
  assign csr_ok    = is_csr && (imm_i == csr_mcycle || imm_i == csr_minstret);

  assign legal = imm_ok || imm_w_ok || reg_ok || reg_w_ok || op_lui || op_auipc ||
                 is_ecall || is_ebreak || csr_ok;

  logic    uses_rs1, uses_rs2, raw_hazard;
  alu_op_e arith_op;

  assign uses_rs1 = op_imm || op_imm_w || op_reg || op_reg_w || (is_csr && !func3[2]);
  assign uses_rs2 = op_reg || op_reg_w;

  assign rs1_addr  = rs1;
  assign rs2_addr  = rs2;
  assign csr_raddr = imm_i;

  assign raw_hazard = ex_valid && ex_rd_wen && (ex_rd != '0) &&
                      ((uses_rs1 && ex_rd == rs1) || (uses_rs2 && ex_rd == rs2));
  // CSR reads wait for EX to drain so minstret and written values are current
  assign ready_go = !(raw_hazard || (is_csr && ex_valid));

  always_comb begin
    case (func3)
      3'd0:    arith_op = ((op_reg || op_reg_w) && inst[30]) ? alu_sub : alu_add;
      3'd1:    arith_op = alu_sll;
      3'd2:    arith_op = alu_slt;
      3'd3:    arith_op = alu_sltu;
      3'd4:    arith_op = alu_xor;
      3'd5:    arith_op = inst[30] ? alu_sra : alu_srl;
      3'd6:    arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
  end

  always_comb begin
    id_ex           = '0;
    id_ex.pc        = pc;
    id_ex.rd        = inst[11:7];
    id_ex.is_word   = op_imm_w || op_reg_w;
    id_ex.csr_rdata = csr_rdata;
    id_ex.alu_op    = arith_op;

    if (op_imm_w || op_reg_w)
      id_ex.op1 = {32'b0, rs1_data[31:0]};
    else
      id_ex.op1 = rs1_data;

    if (op_reg)
      id_ex.op2 = rs2_data;
    else if (op_reg_w)
      id_ex.op2 = {32'b0, rs2_data[31:0]};
    else
      id_ex.op2 = {{(xlen-12){imm_i[11]}}, imm_i};

    if (op_lui || op_auipc) begin
      id_ex.op1    = op_auipc ? pc : '0;
      id_ex.op2    = {{(xlen-32){imm_u[19]}}, imm_u, 12'b0};
      id_ex.alu_op = alu_add;
    end

    if (is_csr) begin
      id_ex.op1 = csr_rdata;
      id_ex.op2 = func3[2] ? {{(xlen-5){1'b0}}, rs1} : rs1_data;
      case (func3[1:0])
        2'd1:    id_ex.alu_op = alu_wri;
        2'd2:    id_ex.alu_op = alu_or;
        default: id_ex.alu_op = alu_andn;
      endcase
    end

    if (is_ecall)
      id_ex.excp = excp_ecall;
    else if (is_ebreak)
      id_ex.excp = excp_ebreak;
    else if (!legal)
      id_ex.excp = excp_illegal;
    else
      id_ex.excp = excp_none;

    id_ex.rd_wen = legal && !is_ecall && !is_ebreak;
    // csrrs/csrrc with a zero source only read
    id_ex.csr_wen  = csr_ok && (func3[1:0] == 2'd1 || rs1 != 5'd0);
    id_ex.csr_addr = csr_ok ? imm_i : '0;
  end

endmodule

`default_nettype wire

// ==== rtl/ex_stage.sv ====
// ex_stage
// ALU with word-form sign extension, CSR new value and retire outputs
`default_nettype none

module ex_stage
  import core_pkg::*;
(
  input  id_ex_t                id_ex,
  output logic                  rd_wen,
  output logic [reg_addr_w-1:0] rd,
  output logic [xlen-1:0]       rd_data,
  output logic                  csr_wen,
  output logic [csr_addr_w-1:0] csr_waddr,
  output logic [xlen-1:0]       csr_wdata,
  output logic [xlen-1:0]       pc,
  output excp_e                 excp
);

  logic [xlen-1:0] op1;
  logic [xlen-1:0] op2;
  logic [5:0]      shamt;
  logic [xlen-1:0] sra_src;
  logic [xlen-1:0] alu_res;
  logic [xlen-1:0] result;
  logic            is_csr;
  logic            no_excp;

  assign op1 = id_ex.op1;
  assign op2 = id_ex.op2;

  // word shifts use five bits, sraw needs the sign of bit 31
  assign shamt   = id_ex.is_word ? {1'b0, op2[4:0]} : op2[5:0];
  assign sra_src = id_ex.is_word ? {{(xlen-32){op1[31]}}, op1[31:0]} : op1;

  always_comb begin
    case (id_ex.alu_op)
      alu_add:  alu_res = op1 + op2;
      alu_sub:  alu_res = op1 - op2;
      alu_slt:  alu_res = {{(xlen-1){1'b0}}, $signed(op1) < $signed(op2)};
      alu_sltu: alu_res = {{(xlen-1){1'b0}}, op1 < op2};
      alu_xor:  alu_res = op1 ^ op2;
      alu_or:   alu_res = op1 | op2;
      alu_and:  alu_res = op1 & op2;
      alu_sll:  alu_res = op1 << shamt;
      alu_srl:  alu_res = op1 >> shamt;
      alu_sra:  alu_res = $signed(sra_src) >>> shamt;
      alu_andn: alu_res = op1 & ~op2;
      alu_wri:  alu_res = op2;
      default:  alu_res = '0;
    endcase
  end

  assign result = id_ex.is_word ? {{(xlen-32){alu_res[31]}}, alu_res[31:0]} : alu_res;

  // only the two counter addresses ever reach EX as a CSR access
  assign is_csr  = (id_ex.csr_addr == csr_mcycle) || (id_ex.csr_addr == csr_minstret);
  assign no_excp = (id_ex.excp == excp_none);

  assign rd      = id_ex.rd;
  assign rd_wen  = id_ex.rd_wen && no_excp;
  assign rd_data = is_csr ? id_ex.csr_rdata : result;

  assign csr_wen   = id_ex.csr_wen && no_excp;
  assign csr_waddr = id_ex.csr_addr;
  assign csr_wdata = alu_res;

  assign pc   = id_ex.pc;
  assign excp = id_ex.excp;

endmodule

`default_nettype wire

// ==== rtl/csr_counters.sv ====
// csr_counters
// mcycle and minstret with one read port and one write port,
// a write takes priority over the increment in its cycle
`default_nettype none

module csr_counters
  import core_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [csr_addr_w-1:0] raddr,
  output logic [xlen-1:0]       rdata,
  input  logic                  wen,
  input  logic [csr_addr_w-1:0] waddr,
  input  logic [xlen-1:0]       wdata,
  input  logic                  retire
);

  logic [xlen-1:0] mcycle;
  logic [xlen-1:0] minstret;

  always_ff @(posedge clk) begin
    if (rst) begin
      mcycle <= '0;
    end else if (wen && waddr == csr_mcycle) begin
      mcycle <= wdata;
    end else begin
      mcycle <= mcycle + 1'b1;
    end
  end

  // the instruction writing minstret does not count itself
  always_ff @(posedge clk) begin
    if (rst) begin
      minstret <= '0;
    end else if (wen && waddr == csr_minstret) begin
      minstret <= wdata;
    end else if (retire) begin
      minstret <= minstret + 1'b1;
    end
  end

  always_comb begin
    case (raddr)
      csr_mcycle:   rdata = mcycle;
      csr_minstret: rdata = minstret;
      default:      rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/core_slice.sv ====
// core_slice
// two-stage RV64 execution slice: ID with register and CSR reads, EX with
// retire port, valid/allowin handshake on input and wb_valid/wb_ready on output
`default_nettype none

module core_slice
  import core_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  output logic                  in_allowin,
  input  logic [31:0]           in_inst,
  input  logic [xlen-1:0]       in_pc,
  output logic                  wb_valid,
  input  logic                  wb_ready,
  output logic [xlen-1:0]       wb_pc,
  output logic [reg_addr_w-1:0] wb_rd,
  output logic                  wb_wen,
  output logic [xlen-1:0]       wb_data,
  output excp_e                 wb_excp
);

  if_id_t                if_id_in, if_id_q;
  id_ex_t                id_ex_d, id_ex_q;
  logic                  id_valid, id_ready_go, ex_allowin, retire;
  logic [reg_addr_w-1:0] rs1_addr, rs2_addr;
  logic [xlen-1:0]       rs1_data, rs2_data, csr_rdata, ex_csr_wdata;
  logic [csr_addr_w-1:0] csr_raddr, ex_csr_waddr;
  logic                  ex_csr_wen;

  assign if_id_in = '{inst: in_inst, pc: in_pc};
  assign retire   = wb_valid && wb_ready;

  stage_reg #(.payload_t(if_id_t)) if_id_r (
    .clk(clk), .rst(rst),
    .in_valid(in_valid), .allowin(in_allowin), .in_data(if_id_in),
    .out_valid(id_valid), .out_data(if_id_q),
    .ready_go(1'b1), .out_allowin(ex_allowin && id_ready_go)
  );

  id_stage id_stage_i (
    .inst(if_id_q.inst), .pc(if_id_q.pc),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .csr_raddr(csr_raddr), .csr_rdata(csr_rdata),
    .ex_valid(wb_valid), .ex_rd(id_ex_q.rd), .ex_rd_wen(id_ex_q.rd_wen),
    .ready_go(id_ready_go), .id_ex(id_ex_d)
  );

  stage_reg #(.payload_t(id_ex_t)) id_ex_r (
    .clk(clk), .rst(rst),
    .in_valid(id_valid && id_ready_go), .allowin(ex_allowin), .in_data(id_ex_d),
    .out_valid(wb_valid), .out_data(id_ex_q),
    .ready_go(1'b1), .out_allowin(wb_ready)
  );

  ex_stage ex_stage_i (
    .id_ex(id_ex_q), .rd_wen(wb_wen), .rd(wb_rd), .rd_data(wb_data),
    .csr_wen(ex_csr_wen), .csr_waddr(ex_csr_waddr), .csr_wdata(ex_csr_wdata),
    .pc(wb_pc), .excp(wb_excp)
  );

  regfile regfile_i (
    .clk(clk), .rst(rst),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .wen(retire && wb_wen), .waddr(wb_rd), .wdata(wb_data)
  );

  csr_counters csr_counters_i (
    .clk(clk), .rst(rst),
    .raddr(csr_raddr), .rdata(csr_rdata),
    .wen(retire && ex_csr_wen), .waddr(ex_csr_waddr), .wdata(ex_csr_wdata),
    .retire(retire)
  );

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
// tb_clock
// free-running clock with period 10 and a 4-cycle reset
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== test/core_slice_assert.sv ====
// core_slice_assert
// retire-port protocol and reset checks, bound into core_slice
`default_nettype none

module core_slice_assert
  import core_pkg::*;
(
  input wire logic                  clk,
  input wire logic                  rst,
  input wire logic                  in_allowin,
  input wire logic                  wb_valid,
  input wire logic                  wb_ready,
  input wire logic [xlen-1:0]       wb_pc,
  input wire logic [reg_addr_w-1:0] wb_rd,
  input wire logic                  wb_wen,
  input wire logic [xlen-1:0]       wb_data,
  input wire excp_e                 wb_excp
);

  // stalled retire keeps its payload
  hold_while_stalled: assert property (@(posedge clk) disable iff (rst)
    wb_valid && !wb_ready |=> wb_valid && $stable(wb_pc) && $stable(wb_rd) &&
      $stable(wb_wen) && $stable(wb_data) && $stable(wb_excp))
    else $error("retire port changed while wb_ready was low");

  empty_after_reset: assert property (@(posedge clk)
    rst |=> !wb_valid && in_allowin)
    else $error("slice not empty after reset");

  // input side only blocks while EX is occupied
  full_blocks_input: assert property (@(posedge clk) disable iff (rst)
    !in_allowin |-> wb_valid)
    else $error("input blocked while EX was empty");

  excp_no_write: assert property (@(posedge clk) disable iff (rst)
    wb_valid && wb_excp != excp_none |-> !wb_wen)
    else $error("exception retired with a register write");

endmodule

bind core_slice core_slice_assert core_slice_assert_i (.*);

`default_nettype wire

// ==== test/core_slice_tb.sv ====
// core_slice_tb
// random RV64 stimulus with stalls, reference register model and retire scoreboard
`default_nettype none

module core_slice_tb
  import core_pkg::*;
();

  logic clk, rst, in_valid, in_allowin, wb_valid, wb_ready, wb_wen;
  logic [31:0] in_inst;
  logic [xlen-1:0] in_pc, wb_pc, wb_data;
  logic [reg_addr_w-1:0] wb_rd;
  excp_e wb_excp;

  logic [31:0] prog[$];
  logic [63:0] model_regs[32];
  logic [63:0] instret;
  logic [63:0] last_mcycle;
  int issued, retired, cycles, limit;

  tb_clock clock_i (.clk(clk), .rst(rst));

  core_slice dut_i (.*);

  task automatic stop_fail(string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check(string name, logic [63:0] exp, logic [63:0] act);
    assert (exp === act) else begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      stop_fail("retire mismatch");
    end
  endtask

  function automatic logic [31:0] gen_arith();
    logic [4:0] rd, rs1, rs2;
    logic [2:0] f3, wf3;
    logic [11:0] imm;
    logic alt;
    rd = 5'($urandom % 8);
    rs1 = 5'($urandom % 8);
    rs2 = 5'($urandom % 8);
    f3 = 3'($urandom);
    wf3 = ($urandom % 3 == 0) ? 3'd0 : ($urandom % 2 == 0) ? 3'd1 : 3'd5;
    imm = 12'($urandom);
    alt = 1'($urandom % 2);
    case ($urandom % 6)
      0: return {(alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h33};
      1: return {(alt && wf3 != 3'd1) ? 7'h20 : 7'h00, rs2, rs1, wf3, rd, 7'h3b};
      2: begin
        if (f3 == 3'd1 || f3 == 3'd5)
          imm[11:6] = (alt && f3 == 3'd5) ? 6'h10 : 6'h00;
        return {imm, rs1, f3, rd, 7'h13};
      end
      3: begin
        if (wf3 != 3'd0)
          imm[11:5] = (alt && wf3 == 3'd5) ? 7'h20 : 7'h00;
        return {imm, rs1, wf3, rd, 7'h1b};
      end
      4: return {20'($urandom), rd, 7'h37};
      default: return {20'($urandom), rd, 7'h17};
    endcase
  endfunction

  // reference arithmetic straight from the RV64I rules
  function automatic logic [63:0] alu_model(logic [31:0] inst, logic [63:0] pc);
    logic [63:0] a, b, r, upper;
    logic [5:0] sh;
    logic is_reg, word;
    is_reg = (inst[6:0] == 7'h33) || (inst[6:0] == 7'h3b);
    word = (inst[6:0] == 7'h3b) || (inst[6:0] == 7'h1b);
    a = model_regs[inst[19:15]];
    b = is_reg ? model_regs[inst[24:20]] : {{52{inst[31]}}, inst[31:20]};
    sh = word ? {1'b0, b[4:0]} : b[5:0];
    upper = {{32{inst[31]}}, inst[31:12], 12'b0};
    if (inst[6:0] == 7'h37)
      return upper;
    if (inst[6:0] == 7'h17)
      return pc + upper;
    case (inst[14:12])
      3'd0: r = (is_reg && inst[30]) ? a - b : a + b;
      3'd1: r = a << sh;
      3'd2: r = {63'b0, $signed(a) < $signed(b)};
      3'd3: r = {63'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (word)
          r = inst[30] ? 64'($signed({{32{a[31]}}, a[31:0]}) >>> sh) : {32'b0, a[31:0]} >> sh;
        else
          r = inst[30] ? 64'($signed(a) >>> sh) : a >> sh;
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return word ? {{32{r[31]}}, r[31:0]} : r;
  endfunction

  task automatic check_retire();
    logic [31:0] inst;
    logic [63:0] exp_data, src, exp_pc;
    logic exp_wen, data_known;
    excp_e exp_excp;
    inst = prog[retired];
    src = model_regs[inst[19:15]];
    exp_pc = 64'h1000 + 64'(4 * retired);
    exp_excp = excp_none;
    exp_wen = 1'b1;
    data_known = 1'b1;
    exp_data = '0;
    check("pc", exp_pc, wb_pc);
    if (inst[6:0] == 7'h73 && inst[14:12] == 3'd0) begin
      exp_excp = inst[20] ? excp_ebreak : excp_ecall;
      exp_wen = 1'b0;
    end else if (inst[6:0] == 7'h03) begin
      exp_excp = excp_illegal;
      exp_wen = 1'b0;
    end else if (inst[6:0] == 7'h73 && inst[31:20] == csr_mcycle) begin
      if (wb_data <= last_mcycle)
        stop_fail("mcycle did not increase between reads");
      last_mcycle = wb_data;
      data_known = 1'b0;
    end else if (inst[6:0] == 7'h73) begin
      exp_data = instret;
    end else begin
      exp_data = alu_model(inst, exp_pc);
    end
    check("excp", 64'(exp_excp), 64'(wb_excp));
    check("wen", 64'(exp_wen), 64'(wb_wen));
    if (exp_wen) begin
      check("rd", 64'(inst[11:7]), 64'(wb_rd));
      if (data_known)
        check("data", exp_data, wb_data);
      if (inst[11:7] != 5'd0)
        model_regs[inst[11:7]] = exp_data;
    end
    // csrrw to minstret replaces the count instead of counting itself
    if (inst[6:0] == 7'h73 && inst[14:12] == 3'd1 && inst[31:20] == csr_minstret)
      instret = src;
    else
      instret = instret + 1;
    retired++;
  endtask

  initial begin
    void'($urandom(32'hb746_da8d));
    in_valid = 1'b0;
    in_inst = '0;
    in_pc = '0;
    wb_ready = 1'b0;
    foreach (model_regs[i]) model_regs[i] = '0;
    instret = '0;
    last_mcycle = '0;
    issued = 0;
    retired = 0;
    repeat (60) prog.push_back(gen_arith());
    prog.push_back({csr_minstret, 5'd0, 3'd2, 5'd1, 7'h73});
    prog.push_back({csr_mcycle, 5'd0, 3'd2, 5'd0, 7'h73});
    repeat (5) prog.push_back(gen_arith());
    prog.push_back({csr_mcycle, 5'd0, 3'd2, 5'd0, 7'h73});
    prog.push_back({csr_minstret, 5'd2, 3'd1, 5'd3, 7'h73});
    repeat (4) prog.push_back(gen_arith());
    prog.push_back({csr_minstret, 5'd0, 3'd2, 5'd4, 7'h73});
    prog.push_back(32'h0000_0073);
    prog.push_back(32'h0010_0073);
    prog.push_back({12'h000, 5'd1, 3'd3, 5'd1, 7'h03});
    repeat (30) prog.push_back(gen_arith());
    limit = 20 * prog.size() + 200;
    @(negedge rst);
    while (retired < prog.size()) begin
      @(negedge clk);
      wb_ready = ($urandom % 4) != 0;
      in_valid = (issued < prog.size()) && ($urandom % 5 != 0);
      if (issued < prog.size()) begin
        in_inst = prog[issued];
        in_pc = 64'h1000 + 64'(4 * issued);
      end
      #1;
      if (wb_valid && wb_ready)
        check_retire();
      if (in_valid && in_allowin)
        issued++;
    end
    in_valid = 1'b0;
    repeat (3) @(negedge clk);
    if (wb_valid) begin
      stop_fail("instruction retired beyond the end of the program");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (limit > 0 && cycles > limit)
        stop_fail("timeout, program did not retire within the cycle limit");
    end
  end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/core_pkg.sv
rtl/stage_reg.sv
rtl/regfile.sv
rtl/id_stage.sv
rtl/ex_stage.sv
rtl/csr_counters.sv
rtl/core_slice.sv
test/tb_clock.sv
test/core_slice_assert.sv
test/core_slice_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core_slice testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module core_slice_tb -o core_slice_sim

./obj_dir/core_slice_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
